// ==== hw/isaPkg.sv ====
package isaPkg;

    localparam int instrWidth   = 32;
    localparam int regAddrWidth = 5;
    localparam int opWidth      = 6;
    localparam int functWidth   = 6;
    localparam int immWidth     = 16;

    // primary opcodes
    localparam logic [opWidth-1:0] opRtype = 6'h00;
    localparam logic [opWidth-1:0] opJ     = 6'h02;
    localparam logic [opWidth-1:0] opBeq   = 6'h04;
    localparam logic [opWidth-1:0] opBne   = 6'h05;
    localparam logic [opWidth-1:0] opBgtz  = 6'h07;
    localparam logic [opWidth-1:0] opAddi  = 6'h08;
    localparam logic [opWidth-1:0] opAndi  = 6'h0c;
    localparam logic [opWidth-1:0] opLw    = 6'h23;
    localparam logic [opWidth-1:0] opSw    = 6'h2b;

    localparam logic [functWidth-1:0] functJr = 6'h08; // only funct told apart

    // one word, two field layouts
    typedef union packed {
        struct packed {
            logic [opWidth-1:0]      opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [regAddrWidth-1:0] rd;
            logic [4:0]              shamt;
            logic [functWidth-1:0]   funct;
        } rType;
        struct packed {
            logic [opWidth-1:0]      opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [immWidth-1:0]     imm;
        } iType;
    } instrWord_u;

    typedef enum logic [3:0] {
        clsLoad, clsStore, clsAlu, clsJr, clsBeq,
        clsBne, clsBgtz, clsImm, clsJump, clsIllegal
    } instrClass_e;

endpackage

// ==== hw/ctrlPkg.sv ====
package ctrlPkg;

    // multicycle control steps
    typedef enum logic [3:0] {
        sFetch,
        sRelease,   // waiting for the ack to drop
        sDecode,
        sMemAddr,
        sMemRead,
        sMemWb,
        sMemWrite,
        sExecR,
        sAluWb,
        sBranch,
        sExecI,
        sImmWb,
        sJump,
        sJumpReg,
        sSettle     // redirect settle window
    } ctrlState_e;

    typedef enum logic [1:0] {
        pcSeq     = 2'b00,
        pcBranch  = 2'b01,
        pcJump    = 2'b10,
        pcJumpReg = 2'b11
    } pcSrc_e;

    typedef enum logic [1:0] {
        aluAdd   = 2'b00,
        aluSub   = 2'b01,
        aluFunct = 2'b10, // alu control looks at funct
        aluImm   = 2'b11  // alu control looks at opcode
    } aluOp_e;

    typedef enum logic [1:0] {
        srcBReg     = 2'b00,
        srcBFour    = 2'b01,
        srcBImm     = 2'b10,
        srcBShifted = 2'b11
    } aluSrcB_e;

endpackage

// ==== hw/instrRegister.sv ====
module instrRegister (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            irWrite,
    input  isaPkg::instrWord_u              instruction,
    output isaPkg::instrClass_e             instrClass,
    output logic [isaPkg::regAddrWidth-1:0] rtAddr,
    output logic [isaPkg::regAddrWidth-1:0] rdAddr
);
    import isaPkg::*;

    instrWord_u irWord;
    logic       irLoaded; // nothing decoded before the first fetch

    always_ff @(posedge clk)
    begin
        if (irWrite)
            irWord <= instruction;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            irLoaded <= 1'b0;
        else if (irWrite)
            irLoaded <= 1'b1;
    end

    // opcode through the I view, funct through the R view
    always_comb
    begin
        instrClass = clsIllegal;
        if (irLoaded)
        begin
            case (irWord.iType.opcode)
                opLw:    instrClass = clsLoad;
                opSw:    instrClass = clsStore;
                opRtype: instrClass = (irWord.rType.funct == functJr) ? clsJr : clsAlu;
                opBeq:   instrClass = clsBeq;
                opBne:   instrClass = clsBne;
                opBgtz:  instrClass = clsBgtz;
                opAddi:  instrClass = clsImm;
                opAndi:  instrClass = clsImm;
                opJ:     instrClass = clsJump;
                default: instrClass = clsIllegal;
            endcase
        end
    end

    assign rtAddr = irWord.iType.rt; // same bits in both views
    assign rdAddr = irWord.rType.rd;

endmodule

// ==== hw/redirectTimer.sv ====
module redirectTimer #(
    parameter int jumpSettle   = 2,
    parameter int branchSettle = 1
) (
    input  logic clk,
    input  logic rst_n,
    input  logic redirectStart,
    input  logic redirectIsJump,
    output logic redirectBusy
);

    localparam int maxSettle = (jumpSettle > branchSettle) ? jumpSettle : branchSettle;
    localparam int cntWidth  = (maxSettle > 1) ? $clog2(maxSettle + 1) : 1;

    // the settle state itself takes the first cycle of the window
    localparam logic [cntWidth-1:0] jumpLoad   =
        cntWidth'((jumpSettle > 0) ? jumpSettle - 1 : 0);
    localparam logic [cntWidth-1:0] branchLoad =
        cntWidth'((branchSettle > 0) ? branchSettle - 1 : 0);

    logic [cntWidth-1:0] count;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            count <= '0;
        else if (redirectStart)
            count <= redirectIsJump ? jumpLoad : branchLoad;
        else if (count != '0)
            count <= count - 1'b1;
    end

    assign redirectBusy = (count != '0);

endmodule

// ==== hw/controlFsm.sv ====
module controlFsm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fetchAck,
    input  isaPkg::instrClass_e  instrClass,
    input  logic                 aluZero,
    input  logic                 aluPositive,
    input  logic                 redirectBusy,
    output logic                 fetchReq,
    output logic                 irWrite,
    output ctrlPkg::ctrlState_e  state,
    output logic                 redirectStart,
    output logic                 redirectIsJump
);
    import isaPkg::*;
    import ctrlPkg::*;

    ctrlState_e nextState;
    logic       branchTaken;

    ////////////////////////////////////////////////////////////
    // branch decision from the alu flags
    always_comb
    begin
        case (instrClass)
            clsBeq:  branchTaken = aluZero;
            clsBne:  branchTaken = !aluZero;
            clsBgtz: branchTaken = aluPositive;
            default: branchTaken = 1'b0;
        endcase
    end

    assign redirectIsJump = (state == sJump) || (state == sJumpReg);
    assign redirectStart  = redirectIsJump || ((state == sBranch) && branchTaken);

    ////////////////////////////////////////////////////////////
    // next state
    always_comb
    begin
        nextState = state;
        case (state)
            sFetch:   if (fetchAck) nextState = sRelease;
            sRelease: if (!fetchAck) nextState = sDecode;
            sDecode:
            begin
                case (instrClass)
                    clsLoad, clsStore:     nextState = sMemAddr;
                    clsAlu:                nextState = sExecR;
                    clsJr:                 nextState = sJumpReg;
                    clsBeq, clsBne, clsBgtz: nextState = sBranch;
                    clsImm:                nextState = sExecI;
                    clsJump:               nextState = sJump;
                    default:               nextState = sFetch; // illegal, just refetch
                endcase
            end
            sMemAddr:  nextState = (instrClass == clsLoad) ? sMemRead : sMemWrite;
            sMemRead:  nextState = sMemWb;
            sMemWb:    nextState = sFetch;
            sMemWrite: nextState = sFetch;
            sExecR:    nextState = sAluWb;
            sAluWb:    nextState = sFetch;
            sBranch:   nextState = branchTaken ? sSettle : sFetch;
            sExecI:    nextState = sImmWb;
            sImmWb:    nextState = sFetch;
            sJump:     nextState = sSettle;
            sJumpReg:  nextState = sSettle;
            sSettle:   if (!redirectBusy) nextState = sFetch;
            default:   nextState = sFetch;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // state and handshake registers
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= sFetch;
            fetchReq <= 1'b0;
            irWrite  <= 1'b0;
        end
        else
        begin
            state    <= nextState;
            fetchReq <= (nextState == sFetch) && !fetchAck; // four-phase rule
            irWrite  <= (state == sFetch) && fetchAck;      // word valid while ack high
        end
    end

endmodule

// ==== hw/controlOutputs.sv ====
module controlOutputs (
    input  ctrlPkg::ctrlState_e  state,
    input  isaPkg::instrClass_e  instrClass,
    output logic                 pcWrite,
    output ctrlPkg::pcSrc_e      pcSrc,
    output logic                 branch,
    output logic                 branchNe,
    output logic                 branchGz,
    output logic                 memToReg,
    output logic                 memWrite,
    output logic                 iorD,
    output logic                 regDst,
    output logic                 regWrite,
    output ctrlPkg::aluOp_e      aluOp,
    output logic                 aluSrcA,
    output ctrlPkg::aluSrcB_e    aluSrcB
);
    import isaPkg::*;
    import ctrlPkg::*;

    always_comb
    begin
        pcWrite  = 1'b0;
        pcSrc    = pcSeq;
        branch   = 1'b0;
        branchNe = 1'b0;
        branchGz = 1'b0;
        memToReg = 1'b0;
        memWrite = 1'b0;
        iorD     = 1'b0;
        regDst   = 1'b0;
        regWrite = 1'b0;
        aluOp    = aluAdd;
        aluSrcA  = 1'b0;
        aluSrcB  = srcBReg;

        case (state)
            sDecode:
            begin
                pcWrite = 1'b1;       // pc+4 once the word sits in the IR
                aluSrcB = srcBFour;
            end
            sMemAddr:
            begin
                aluSrcA = 1'b1;
                aluSrcB = srcBImm;    // base + offset
            end
            sMemRead:  iorD = 1'b1;
            sMemWb:
            begin
                regWrite = 1'b1;
                memToReg = 1'b1;
            end
            sMemWrite:
            begin
                iorD     = 1'b1;
                memWrite = 1'b1;
            end
            sExecR:
            begin
                aluSrcA = 1'b1;
                aluOp   = aluFunct;
            end
            sAluWb:
            begin
                regWrite = 1'b1;
                regDst   = 1'b1;      // rd target only for R types
            end
            sBranch:
            begin
                aluSrcA  = 1'b1;
                aluOp    = aluSub;    // compare rs against rt
                pcSrc    = pcBranch;
                branch   = (instrClass == clsBeq);
                branchNe = (instrClass == clsBne);
                branchGz = (instrClass == clsBgtz);
            end
            sExecI:
            begin
                aluSrcA = 1'b1;
                aluSrcB = srcBImm;
                aluOp   = aluImm;     // addi or andi from the opcode
            end
            sImmWb:    regWrite = 1'b1;
            sJump:
            begin
                pcWrite = 1'b1;
                pcSrc   = pcJump;
            end
            sJumpReg:
            begin
                pcWrite = 1'b1;
                pcSrc   = pcJumpReg;
            end
            default: ;
        endcase
    end

endmodule

// ==== hw/cpuControlTop.sv ====
module cpuControlTop #(
    parameter int jumpSettle   = 2,
    parameter int branchSettle = 1
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  isaPkg::instrWord_u              instruction,
    input  logic                            aluZero,
    input  logic                            aluPositive,
    input  logic                            fetchAck,
    output logic                            fetchReq,
    output logic                            pcWrite,
    output ctrlPkg::pcSrc_e                 pcSrc,
    output logic                            branch,
    output logic                            branchNe,
    output logic                            branchGz,
    output logic                            memToReg,
    output logic                            memWrite,
    output logic                            iorD,
    output logic [isaPkg::regAddrWidth-1:0] rtAddr,
    output logic [isaPkg::regAddrWidth-1:0] rdAddr,
    output logic                            regDst,
    output logic                            regWrite,
    output ctrlPkg::aluOp_e                 aluOp,
    output logic                            aluSrcA,
    output ctrlPkg::aluSrcB_e               aluSrcB,
    output logic                            irWrite
);
    import isaPkg::*;
    import ctrlPkg::*;

    instrClass_e instrClass;
    ctrlState_e  state;
    logic        redirectStart;
    logic        redirectIsJump;
    logic        redirectBusy;

    instrRegister ir_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .irWrite     (irWrite),
        .instruction (instruction),
        .instrClass  (instrClass),
        .rtAddr      (rtAddr),
        .rdAddr      (rdAddr)
    );

    controlFsm fsm_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetchAck       (fetchAck),
        .instrClass     (instrClass),
        .aluZero        (aluZero),
        .aluPositive    (aluPositive),
        .redirectBusy   (redirectBusy),
        .fetchReq       (fetchReq),
        .irWrite        (irWrite),
        .state          (state),
        .redirectStart  (redirectStart),
        .redirectIsJump (redirectIsJump)
    );

    redirectTimer #(
        .jumpSettle   (jumpSettle),
        .branchSettle (branchSettle)
    ) timer_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .redirectStart  (redirectStart),
        .redirectIsJump (redirectIsJump),
        .redirectBusy   (redirectBusy)
    );

    controlOutputs outs_i (
        .state      (state),
        .instrClass (instrClass),
        .pcWrite    (pcWrite),
        .pcSrc      (pcSrc),
        .branch     (branch),
        .branchNe   (branchNe),
        .branchGz   (branchGz),
        .memToReg   (memToReg),
        .memWrite   (memWrite),
        .iorD       (iorD),
        .regDst     (regDst),
        .regWrite   (regWrite),
        .aluOp      (aluOp),
        .aluSrcA    (aluSrcA),
        .aluSrcB    (aluSrcB)
    );

endmodule

// ==== testbench/stimulusTable.svh ====
`ifndef STIMULUS_TABLE_SVH
`define STIMULUS_TABLE_SVH

// fetchReq rise to decode
// one cycle of req before the ack, the ack cycle, two cycles in sRelease
localparam int fetchOverhead = 4;

// class path lengths, decode included
localparam int pathLoad    = 4;
localparam int pathStore   = 3;
localparam int pathR       = 3;
localparam int pathImm     = 3;
localparam int pathBranch  = 2;
localparam int pathJump    = 2;
localparam int pathIllegal = 1;

localparam int jumpSettleCycles   = 2;
localparam int branchSettleCycles = 1;

typedef struct packed {
    logic [opWidth-1:0]    opcode;
    logic [functWidth-1:0] funct;     // only looked at with opRtype
    logic                  zero;
    logic                  positive;
    int                    gap;       // fetchReq rise to the next rise
    int                    regWrites;
    int                    memWrites;
    pcSrc_e                pcSrc;     // redirect source, pcSeq if none
    logic [2:0]            flags;     // {branch, branchNe, branchGz}
    logic                  regDst;
    int                    aluUses;   // cycles with aluSrcA high
    aluOp_e                aluOp;     // during those cycles
    aluSrcB_e              aluSrcB;
} stimRow_s;

localparam int numRows = 15;

// opcode funct zero pos gap
//   regW memW pcSrc flags regDst aluUses aluOp aluSrcB
localparam stimRow_s stimTable [numRows] = '{
    '{opRtype, 6'h20, 1'b0, 1'b0, fetchOverhead + pathR,
      1, 0, pcSeq, 3'b000, 1'b1, 1, aluFunct, srcBReg},
    '{opLw, 6'h00, 1'b0, 1'b0, fetchOverhead + pathLoad,
      1, 0, pcSeq, 3'b000, 1'b0, 1, aluAdd, srcBImm},
    '{opSw, 6'h00, 1'b0, 1'b0, fetchOverhead + pathStore,
      0, 1, pcSeq, 3'b000, 1'b0, 1, aluAdd, srcBImm},
    '{opAddi, 6'h00, 1'b0, 1'b0, fetchOverhead + pathImm,
      1, 0, pcSeq, 3'b000, 1'b0, 1, aluImm, srcBImm},
    '{opAndi, 6'h00, 1'b1, 1'b0, fetchOverhead + pathImm,
      1, 0, pcSeq, 3'b000, 1'b0, 1, aluImm, srcBImm},
    '{opBeq, 6'h00, 1'b1, 1'b0, fetchOverhead + pathBranch + branchSettleCycles,
      0, 0, pcBranch, 3'b100, 1'b0, 1, aluSub, srcBReg},
    '{opBeq, 6'h00, 1'b0, 1'b1, fetchOverhead + pathBranch,
      0, 0, pcBranch, 3'b100, 1'b0, 1, aluSub, srcBReg},
    '{opBne, 6'h00, 1'b0, 1'b0, fetchOverhead + pathBranch + branchSettleCycles,
      0, 0, pcBranch, 3'b010, 1'b0, 1, aluSub, srcBReg},
    '{opBne, 6'h00, 1'b1, 1'b0, fetchOverhead + pathBranch,
      0, 0, pcBranch, 3'b010, 1'b0, 1, aluSub, srcBReg},
    '{opBgtz, 6'h00, 1'b0, 1'b1, fetchOverhead + pathBranch + branchSettleCycles,
      0, 0, pcBranch, 3'b001, 1'b0, 1, aluSub, srcBReg},
    '{opBgtz, 6'h00, 1'b1, 1'b0, fetchOverhead + pathBranch,
      0, 0, pcBranch, 3'b001, 1'b0, 1, aluSub, srcBReg},
    '{opJ, 6'h00, 1'b0, 1'b0, fetchOverhead + pathJump + jumpSettleCycles,
      0, 0, pcJump, 3'b000, 1'b0, 0, aluAdd, srcBReg},
    '{opRtype, functJr, 1'b0, 1'b0, fetchOverhead + pathJump + jumpSettleCycles,
      0, 0, pcJumpReg, 3'b000, 1'b0, 0, aluAdd, srcBReg},
    '{6'h3f, 6'h00, 1'b0, 1'b0, fetchOverhead + pathIllegal,
      0, 0, pcSeq, 3'b000, 1'b0, 0, aluAdd, srcBReg},
    '{opRtype, 6'h22, 1'b1, 1'b1, fetchOverhead + pathR,
      1, 0, pcSeq, 3'b000, 1'b1, 1, aluFunct, srcBReg}
};

`endif

// ==== testbench/cpuControlTb.sv ====
module cpuControlTb;
    import isaPkg::*;
    import ctrlPkg::*;

    `include "stimulusTable.svh"

    localparam int clkPeriod    = 20;
    localparam int marginCycles = 20;

    logic       clk         = 1'b0;
    logic       rst_n;
    instrWord_u instruction = '0;
    logic       aluZero;
    logic       aluPositive;
    logic       fetchAck    = 1'b0;

    logic                    fetchReq;
    logic                    pcWrite;
    pcSrc_e                  pcSrc;
    logic                    branch;
    logic                    branchNe;
    logic                    branchGz;
    logic                    memToReg;
    logic                    memWrite;
    logic                    iorD;
    logic [regAddrWidth-1:0] rtAddr;
    logic [regAddrWidth-1:0] rdAddr;
    logic                    regDst;
    logic                    regWrite;
    aluOp_e                  aluOp;
    logic                    aluSrcA;
    aluSrcB_e                aluSrcB;
    logic                    irWrite;

    instrWord_u  words [numRows]; // one fetched word per table row
    int          fetchIndex = 0;
    logic [31:0] randState  = 32'hbfa344e1;
    int          currentRow = 0;
    int          errorCount = 0;
    int          checkCount = 0;

    cpuControlTop #(
        .jumpSettle   (jumpSettleCycles),
        .branchSettle (branchSettleCycles)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instruction (instruction),
        .aluZero     (aluZero),
        .aluPositive (aluPositive),
        .fetchAck    (fetchAck),
        .fetchReq    (fetchReq),
        .pcWrite     (pcWrite),
        .pcSrc       (pcSrc),
        .branch      (branch),
        .branchNe    (branchNe),
        .branchGz    (branchGz),
        .memToReg    (memToReg),
        .memWrite    (memWrite),
        .iorD        (iorD),
        .rtAddr      (rtAddr),
        .rdAddr      (rdAddr),
        .regDst      (regDst),
        .regWrite    (regWrite),
        .aluOp       (aluOp),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .irWrite     (irWrite)
    );

    always #(clkPeriod / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // instruction memory, four-phase ack one edge after the req
    always @(posedge clk)
    begin
        if (fetchReq && !fetchAck)
        begin
            fetchAck <= 1'b1;
            if (fetchIndex < numRows)
                instruction <= words[fetchIndex];
            fetchIndex <= fetchIndex + 1;
        end
        else if (!fetchReq && fetchAck)
        begin
            fetchAck    <= 1'b0;
            instruction <= ~instruction; // garbage once the word is released
        end
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] value);
        return value * 32'd1664525 + 32'd1013904223;
    endfunction

    // random register fields, opcode and funct from the table
    function automatic void buildWords();
        int i;
        for (i = 0; i < numRows; i++)
        begin
            randState = nextRandom(randState);
            words[i]  = randState;
            words[i].iType.opcode = stimTable[i].opcode;
            if (stimTable[i].opcode == opRtype)
                words[i].rType.funct = stimTable[i].funct;
        end
    endfunction

    task automatic checkValue(input string name, input int actual, input int expected);
        checkCount++;
        if (actual != expected)
        begin
            errorCount++;
            $display("Mismatch at %0t, row %0d: %s is %0d, expected %0d",
                     $time, currentRow, name, actual, expected);
        end
    endtask

    task automatic waitForFetch;
        while (!fetchReq)
            @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // one instruction, from its fetchReq rise to the next one
    task automatic runRow(input int row);
        int         cycles;
        int         regWrites;
        int         memWrites;
        int         irWrites;
        int         seqWrites;
        int         memAccesses;
        int         memToRegs;
        int         aluUses;
        int         redirectSrc;
        logic [2:0] flagsSeen;
        logic       lastReq;
        logic       rising;
        logic       isLoad;
        logic       isMemOp;
        cycles      = 0;
        regWrites   = 0;
        memWrites   = 0;
        irWrites    = 0;
        seqWrites   = 0;
        memAccesses = 0;
        memToRegs   = 0;
        aluUses     = 0;
        redirectSrc = int'(pcSeq);
        flagsSeen   = 3'b000;
        lastReq     = 1'b1;
        currentRow  = row;
        isLoad      = (stimTable[row].opcode == opLw);
        isMemOp     = isLoad || (stimTable[row].opcode == opSw);
        @(posedge clk);
        aluZero     <= stimTable[row].zero;
        aluPositive <= stimTable[row].positive;
        do
        begin
            @(negedge clk);
            cycles++;
            if (regWrite)
            begin
                regWrites++;
                checkValue("rtAddr", int'(rtAddr), int'(words[row].iType.rt));
                checkValue("rdAddr", int'(rdAddr), int'(words[row].rType.rd));
                checkValue("regDst", int'(regDst), int'(stimTable[row].regDst));
                checkValue("memToReg", int'(memToReg), int'(isLoad));
            end
            if (memWrite)
            begin
                memWrites++;
                checkValue("iorD", int'(iorD), 1); // store address from the alu
            end
            if (iorD)
                memAccesses++;
            if (memToReg)
                memToRegs++;
            if (aluSrcA)
            begin
                aluUses++;
                checkValue("aluOp", int'(aluOp), int'(stimTable[row].aluOp));
                checkValue("aluSrcB", int'(aluSrcB), int'(stimTable[row].aluSrcB));
            end
            if (irWrite)
                irWrites++;
            if (pcWrite && pcSrc == pcSeq)
                seqWrites++;
            if (branch || branchNe || branchGz || (pcWrite && pcSrc != pcSeq))
                redirectSrc = int'(pcSrc);
            flagsSeen = flagsSeen | {branch, branchNe, branchGz};
            rising    = fetchReq && !lastReq;
            lastReq   = fetchReq;
        end while (!rising);

        checkValue("fetchReq gap", cycles, stimTable[row].gap);
        checkValue("regWrite cycles", regWrites, stimTable[row].regWrites);
        checkValue("memWrite cycles", memWrites, stimTable[row].memWrites);
        checkValue("iorD cycles", memAccesses, int'(isMemOp));
        checkValue("memToReg cycles", memToRegs, int'(isLoad));
        checkValue("aluSrcA cycles", aluUses, stimTable[row].aluUses);
        checkValue("irWrite cycles", irWrites, 1);
        checkValue("pcWrite pcSeq cycles", seqWrites, 1); // once per fetch
        checkValue("pcSrc", redirectSrc, int'(stimTable[row].pcSrc));
        checkValue("branch flags", int'(flagsSeen), int'(stimTable[row].flags));
    endtask

    initial
    begin : mainSequence
        int row;
        rst_n       <= 1'b0;
        aluZero     <= 1'b0;
        aluPositive <= 1'b0;
        buildWords();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        waitForFetch();
        for (row = 0; row < numRows; row++)
            runRow(row);
        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial
    begin : watchdog
        int limit;
        int i;
        limit = 4 + marginCycles; // reset and the first request
        for (i = 0; i < numRows; i++)
            limit += stimTable[i].gap;
        #(limit * clkPeriod);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+testbench
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/instrRegister.sv
hw/redirectTimer.sv
hw/controlFsm.sv
hw/controlOutputs.sv
hw/cpuControlTop.sv
testbench/cpuControlTb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run with Verilator, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --top-module cpuControlTb -f src.f -Mdir obj_dir \
    > build.log 2>&1 \
    && ./obj_dir/VcpuControlTb > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -qx "TEST OK" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
